//--- decode.sv
// Control decode, register file, immediate extension and reserved-bit check
module decode (
   input  logic            clk,
   input  logic            reset,
   input  procPkg::wordT   instr,
   input  logic            wbEn,
   input  procPkg::regIdxT wbIdx,
   input  procPkg::wordT   wbData,
   output procPkg::ctrlT   ctrl,
   output procPkg::regIdxT rdIdx,
   output procPkg::wordT   rsData,
   output procPkg::wordT   rtData,
   output procPkg::wordT   rdData,
   output procPkg::wordT   imm,
   output logic            decodeErr
);
   import procPkg::*;

   wordT   regs [numRegs];
   opcodeT op;
   wordT   sext6;
   wordT   sext9;
   wordT   sext12;
   wordT   zext8;

   assign op = opcodeT'(instr[wordWidth-1 -: opWidth]);

   // Immediate candidates
   assign sext6  = {{(wordWidth-imm6Width){instr[imm6Width-1]}}, instr[imm6Width-1:0]};
   assign sext9  = {{(wordWidth-imm9Width){instr[imm9Width-1]}}, instr[imm9Width-1:0]};
   assign sext12 = {{(wordWidth-imm12Width){instr[imm12Width-1]}}, instr[imm12Width-1:0]};
   assign zext8  = {{(wordWidth-imm8Width){1'b0}}, instr[imm8Width-1:0]};

   // Control and immediate per opcode
   always_comb begin
      ctrl = '0;
      ctrl.op = op;
      imm = '0;
      case (op)
         opHalt: ctrl.halt = 1'b1;
         opNop: ;
         opAdd, opSub, opAnd, opXor: ctrl.regWrite = 1'b1;
         opAddi: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            imm = sext6;
         end
         opLbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            imm = sext9;
         end
         opSlbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            imm = zext8;
         end
         opLd: begin
            ctrl.regWrite = 1'b1;
            ctrl.memRead = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            imm = sext6;
         end
         opSt: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            imm = sext6;
         end
         opBeqz: begin
            ctrl.branch = 1'b1;
            ctrl.branchOnZero = 1'b1;
            imm = sext9;
         end
         opBnez: begin
            ctrl.branch = 1'b1;
            imm = sext9;
         end
         opJ: begin
            ctrl.jump = 1'b1;
            imm = sext12;
         end
         opJal: begin
            ctrl.jump = 1'b1;
            ctrl.link = 1'b1;
            ctrl.regWrite = 1'b1;
            imm = sext12;
         end
         opJr: begin
            ctrl.jumpReg = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            imm = sext6;
         end
      endcase
   end

   // JAL overrides the destination with r7
   assign rdIdx = (op == opJal) ? regIdxT'(linkReg) : instr[11:9];

   // Three read ports, rd doubles as store data and branch test
   assign rsData = regs[instr[8:6]];
   assign rtData = regs[instr[5:3]];
   assign rdData = regs[instr[11:9]];

   // Write lands at end of cycle
   always_ff @(posedge clk) begin
      if (wbEn) begin
         regs[wbIdx] <= wbData;
      end
   end

   // R-type low bits reserved
   assign decodeErr = (op inside {opAdd, opSub, opAnd, opXor}) && (instr[2:0] != 3'b000);

   // Writeback index comes back from memory stage
   linkToR7: assert property (@(posedge clk) disable iff (reset)
      (wbEn && ctrl.link) |-> (wbIdx == regIdxT'(linkReg)));

endmodule

//--- execute.sv
// ALU, branch condition and next-PC selection
module execute (
   input  procPkg::ctrlT ctrl,
   input  procPkg::wordT pc,
   input  procPkg::wordT pcInc,
   input  procPkg::wordT rsData,
   input  procPkg::wordT rtData,
   input  procPkg::wordT rdData,
   input  procPkg::wordT imm,
   output procPkg::wordT aluOut,
   output procPkg::wordT nextPc
);
   import procPkg::*;

   wordT operandB;
   wordT pcRelTarget;
   logic rdZero;
   logic branchTaken;

   // Second operand, register or immediate
   assign operandB = ctrl.aluSrcImm ? imm : rtData;

   always_comb begin
      case (ctrl.op)
         // rs minus rt
         opSub: aluOut = rsData - rtData;
         opAnd: aluOut = rsData & operandB;
         opXor: aluOut = rsData ^ operandB;
         // Immediate pass-through
         opLbi: aluOut = imm;
         // Old rd low byte moves up, imm fills low byte
         opSlbi: aluOut = {rdData[7:0], 8'h00} | imm;
         // ADD, ADDI, LD/ST address, JR target
         default: aluOut = rsData + operandB;
      endcase
   end

   // Zero test on rd for BEQZ and BNEZ
   assign rdZero = (rdData == '0);
   assign branchTaken = ctrl.branch && (ctrl.branchOnZero ? rdZero : !rdZero);

   // Branch and J/JAL share the pc+1 relative target
   assign pcRelTarget = pcInc + imm;

   always_comb begin
      if (ctrl.halt) begin
         // Hold on HALT
         nextPc = pc;
      end else if (ctrl.jumpReg) begin
         // rs plus imm6 from the ALU
         nextPc = aluOut;
      end else if (ctrl.jump || branchTaken) begin
         nextPc = pcRelTarget;
      end else begin
         nextPc = pcInc;
      end
   end

endmodule

//--- fetch.sv
// Program counter register, instruction ROM, PC increment and halt freeze
module fetch (
   input  logic          clk,
   input  logic          reset,
   input  procPkg::wordT nextPc,
   output procPkg::wordT pc,
   output procPkg::wordT pcInc,
   output procPkg::wordT instr,
   output logic          halted
);
   import procPkg::*;

   wordT rom [imemDepth];
   logic isHalt;

   // Program image
   initial begin
      $readmemh("program.hex", rom);
   end

   // Word addressed, upper PC bits ignored
   assign instr = rom[pc[imemAddrWidth-1:0]];
   assign pcInc = pc + wordT'(1);

   // Own halt detect so the freeze needs no decode path
   assign isHalt = (opcodeT'(instr[wordWidth-1 -: opWidth]) == opHalt);

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= resetPc;
         halted <= 1'b0;
      end else begin
         // Freeze on HALT
         if (!isHalt) begin
            pc <= nextPc;
         end
         // Sticky until reset
         if (isHalt) begin
            halted <= 1'b1;
         end
      end
   end

   // Halted core never moves again
   haltedPcStable: assert property (@(posedge clk) disable iff (reset)
      halted |=> $stable(pc));

endmodule

//--- files.f
procPkg.sv
fetch.sv
decode.sv
execute.sv
memory.sv
proc.sv
procTb.sv

//--- memory.sv
// Data RAM, output-port register, writeback select and sticky error flag
module memory (
   input  logic              clk,
   input  logic              reset,
   input  procPkg::ctrlT     ctrl,
   input  procPkg::wordT     aluOut,
   input  procPkg::wordT     rdData,
   input  procPkg::wordT     pcInc,
   input  procPkg::regIdxT   rdIdx,
   input  logic              decodeErr,
   output logic              wbEn,
   output procPkg::regIdxT   wbIdx,
   output procPkg::wordT     wbData,
   output procPkg::ioWriteT  ioOut,
   output logic              err
);
   import procPkg::*;

   wordT                   ram [dmemDepth];
   wordT                   loadData;
   logic                   isIo;
   logic                   ioValid;
   logic [ioAddrWidth-1:0] ioAddr;
   wordT                   ioData;

   // Address bit 15 selects the output region
   assign isIo = aluOut[ioRegionBit];

   // Combinational load
   assign loadData = ram[aluOut[dmemAddrWidth-1:0]];

   always_ff @(posedge clk) begin
      if (ctrl.memWrite && !isIo) begin
         ram[aluOut[dmemAddrWidth-1:0]] <= rdData;
      end
   end

   // Output payload, only captured on an IO store
   always_ff @(posedge clk) begin
      if (ctrl.memWrite && isIo) begin
         ioAddr <= aluOut[ioAddrWidth-1:0];
         ioData <= rdData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ioValid <= 1'b0;
         err <= 1'b0;
      end else begin
         // One-cycle strobe
         ioValid <= ctrl.memWrite && isIo;
         // Bad R-type or load from write-only port
         if (decodeErr || (ctrl.memRead && isIo)) begin
            err <= 1'b1;
         end
      end
   end

   assign ioOut = '{valid: ioValid, addr: ioAddr, data: ioData};

   // Writeback, link beats load beats ALU
   assign wbEn = ctrl.regWrite;
   assign wbIdx = rdIdx;
   assign wbData = ctrl.link ? pcInc : (ctrl.memToReg ? loadData : aluOut);

   // Strobe only follows a store
   ioAfterStore: assert property (@(posedge clk) disable iff (reset)
      ioOut.valid |-> $past(ctrl.op == opSt));

endmodule

//--- proc.sv
// Top level of the single-cycle core, four stages wired together
module proc (
   input  logic             clk,
   input  logic             reset,
   output procPkg::ioWriteT ioOut,
   output logic             halted,
   output logic             err
);
   import procPkg::*;

   // Fetch outputs
   wordT    pc;
   wordT    pcInc;
   wordT    instr;
   // Decode outputs
   ctrlT    ctrl;
   regIdxT  rdIdx;
   wordT    rsData;
   wordT    rtData;
   wordT    rdData;
   wordT    imm;
   logic    decodeErr;
   // Execute outputs
   wordT    aluOut;
   wordT    nextPc;
   // Writeback back to the register file
   logic    wbEn;
   regIdxT  wbIdx;
   wordT    wbData;

   fetch fetch_i (
      .clk(clk), .reset(reset), .nextPc(nextPc),
      .pc(pc), .pcInc(pcInc), .instr(instr), .halted(halted)
   );

   decode decode_i (
      .clk(clk), .reset(reset), .instr(instr),
      .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData),
      .ctrl(ctrl), .rdIdx(rdIdx), .rsData(rsData), .rtData(rtData),
      .rdData(rdData), .imm(imm), .decodeErr(decodeErr)
   );

   execute execute_i (
      .ctrl(ctrl), .pc(pc), .pcInc(pcInc), .rsData(rsData), .rtData(rtData),
      .rdData(rdData), .imm(imm), .aluOut(aluOut), .nextPc(nextPc)
   );

   // Memory stage also does writeback
   memory memory_i (
      .clk(clk), .reset(reset), .ctrl(ctrl), .aluOut(aluOut), .rdData(rdData),
      .pcInc(pcInc), .rdIdx(rdIdx), .decodeErr(decodeErr),
      .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData), .ioOut(ioOut), .err(err)
   );

endmodule

//--- procPkg.sv
// Opcodes, field and memory widths, control and output-port structs
package procPkg;

   // Datapath and instruction field widths
   localparam int wordWidth = 16;
   localparam int opWidth = 4;
   localparam int regIdxWidth = 3;
   localparam int numRegs = 8;
   localparam int imm6Width = 6;
   localparam int imm8Width = 8;
   localparam int imm9Width = 9;
   localparam int imm12Width = 12;

   // Memory sizes in words
   localparam int imemDepth = 256;
   localparam int dmemDepth = 256;
   localparam int imemAddrWidth = $clog2(imemDepth);
   localparam int dmemAddrWidth = $clog2(dmemDepth);

   // Output port region and address width
   localparam int ioRegionBit = 15;
   localparam int ioAddrWidth = 8;

   localparam logic [wordWidth-1:0] resetPc = '0;
   // JAL link target
   localparam int linkReg = 7;

   typedef logic [wordWidth-1:0] wordT;
   typedef logic [regIdxWidth-1:0] regIdxT;

   // Top four instruction bits
   typedef enum logic [opWidth-1:0] {
      opHalt = 4'd0,
      opNop  = 4'd1,
      opAdd  = 4'd2,
      opSub  = 4'd3,
      opAnd  = 4'd4,
      opXor  = 4'd5,
      opAddi = 4'd6,
      opLbi  = 4'd7,
      opSlbi = 4'd8,
      opLd   = 4'd9,
      opSt   = 4'd10,
      opBeqz = 4'd11,
      opBnez = 4'd12,
      opJ    = 4'd13,
      opJal  = 4'd14,
      opJr   = 4'd15
   } opcodeT;

   // Decoded control, fans out to execute and memory
   typedef struct packed {
      opcodeT op;
      logic   regWrite;
      logic   memRead;
      logic   memWrite;
      logic   memToReg;
      logic   link;
      logic   branch;
      logic   branchOnZero;
      logic   jump;
      logic   jumpReg;
      logic   aluSrcImm;
      logic   halt;
   } ctrlT;

   // One-cycle output write strobe
   typedef struct packed {
      logic                   valid;
      logic [ioAddrWidth-1:0] addr;
      wordT                   data;
   } ioWriteT;

endpackage

//--- procTb.sv
// Clock, reset, output-write monitor and checks for the single-cycle core
module procTb;
   import procPkg::*;

   localparam int numWrites = 14;
   localparam int haltTimeout = 500;
   localparam int quietCycles = 30;

   logic    clk;
   logic    reset;
   ioWriteT ioOut;
   logic    halted;
   logic    err;

   // Expected output writes in order
   ioWriteT expTable [numWrites];
   int      writeCount;

   proc dut_i (
      .clk(clk), .reset(reset), .ioOut(ioOut), .halted(halted), .err(err)
   );

   // Period 8
   always begin
      #4 clk = ~clk;
   end

   task automatic abortRun();
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic flagMismatch(input string name, input wordT expected, input wordT actual);
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      abortRun();
   endtask

   task automatic describeFailure(input string what);
      $display("%s", what);
      abortRun();
   endtask

   function automatic ioWriteT makeEntry(input logic [7:0] addr, input wordT data);
      makeEntry = '{valid: 1'b1, addr: addr, data: data};
   endfunction

   // Worked out by hand from the ISA
   // r1 = 0x1234 and r2 = 0x5678 after LBI and SLBI
   task automatic buildTable();
      expTable[0]  = makeEntry(8'd0, 16'h1234 + 16'h5678);
      expTable[1]  = makeEntry(8'd1, 16'h1234 - 16'h5678);
      expTable[2]  = makeEntry(8'd2, 16'h1234 & 16'h5678);
      expTable[3]  = makeEntry(8'd3, 16'h1234 ^ 16'h5678);
      // ADDI with imm6 of -3
      expTable[4]  = makeEntry(8'd4, 16'h1234 - 16'd3);
      // LBI sign extends 0x1fe
      expTable[5]  = makeEntry(8'd5, 16'hfffe);
      // SLBI moves 0x56 up and ORs in 0x78
      expTable[6]  = makeEntry(8'd6, 16'h5678);
      // RAM round trip of the XOR value and r1
      expTable[7]  = makeEntry(8'd7, 16'h1234 ^ 16'h5678);
      expTable[8]  = makeEntry(8'd8, 16'h1234);
      // Taken BEQZ, not-taken BNEZ, taken BNEZ followed by not-taken BEQZ
      expTable[9]  = makeEntry(8'd9, 16'h00a1);
      expTable[10] = makeEntry(8'd10, 16'h00a2);
      expTable[11] = makeEntry(8'd11, 16'h00a3);
      // JAL sits at word 41
      expTable[12] = makeEntry(8'd12, 16'd41 + 16'd1);
      // Marker written after JR came back
      expTable[13] = makeEntry(8'd13, 16'h00b0);
   endtask

   // Output-write monitor sampled mid-cycle
   always @(negedge clk) begin
      if (reset) begin
         writeCount <= 0;
      end else if (ioOut.valid) begin
         assert (writeCount < numWrites) else
            describeFailure($sformatf("Unexpected extra output write to address %0d",
                                      ioOut.addr));
         assert (ioOut.addr == expTable[writeCount].addr) else
            flagMismatch($sformatf("write %0d address", writeCount),
                         wordT'(expTable[writeCount].addr), wordT'(ioOut.addr));
         assert (ioOut.data == expTable[writeCount].data) else
            flagMismatch($sformatf("write %0d data", writeCount),
                         expTable[writeCount].data, ioOut.data);
         // Trap comes only after the last write
         assert (!err) else
            flagMismatch($sformatf("err during write %0d", writeCount), 16'd0, 16'd1);
         writeCount <= writeCount + 1;
      end
   end

   // Hold reset 5 cycles and then check the idle state
   task automatic applyReset();
      reset = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      assert (!halted) else
         flagMismatch("halted after reset", 16'd0, wordT'(halted));
      assert (!err) else
         flagMismatch("err after reset", 16'd0, wordT'(err));
      assert (!ioOut.valid) else
         flagMismatch("ioOut.valid after reset", 16'd0, wordT'(ioOut.valid));
      reset = 1'b0;
   endtask

   task automatic runProgram(input string runName);
      int cycles;
      cycles = 0;
      // Run to HALT
      // err may only be high once every write is seen
      while (!halted && cycles < haltTimeout) begin
         @(negedge clk);
         assert (!err || writeCount == numWrites) else
            flagMismatch({runName, " err before final trap"}, 16'd0, 16'd1);
         cycles++;
      end
      assert (halted) else
         describeFailure({"Timed out waiting for halted in ", runName});
      assert (writeCount == numWrites) else
         flagMismatch({runName, " write count at halt"},
                      wordT'(numWrites), wordT'(writeCount));
      assert (err) else
         flagMismatch({runName, " err after load trap"}, 16'd1, 16'd0);
      // Halted core stays quiet with flags up
      repeat (quietCycles) begin
         @(negedge clk);
         assert (halted) else
            describeFailure({"halted dropped while halted in ", runName});
         assert (err) else
            describeFailure({"err is not sticky in ", runName});
      end
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      buildTable();
      applyReset();
      runProgram("first run");
      // Restart and run the whole sequence again
      @(posedge clk);
      #1;
      applyReset();
      runProgram("after restart");
      $display("Test OK");
      $finish;
   end

endmodule

//--- program.hex
// Instruction ROM image, one 16-bit hex word per line, word address given in the comment
// Word layout op[15:12] rd[11:9] rs[8:6] rt[5:3] imm6[5:0], imm9[8:0], imm12[11:0]
7D00 // 0  LBI  r6, -256      output region base 0xff00
7212 // 1  LBI  r1, 0x12
8234 // 2  SLBI r1, 0x34      r1 = 0x1234
7456 // 3  LBI  r2, 0x56
8478 // 4  SLBI r2, 0x78      r2 = 0x5678
2650 // 5  ADD  r3, r1, r2
A780 // 6  ST   r3, r6, 0
3850 // 7  SUB  r4, r1, r2
A981 // 8  ST   r4, r6, 1
4A50 // 9  AND  r5, r1, r2
AB82 // 10 ST   r5, r6, 2
5650 // 11 XOR  r3, r1, r2
A783 // 12 ST   r3, r6, 3
687D // 13 ADDI r4, r1, -3
A984 // 14 ST   r4, r6, 4
7BFE // 15 LBI  r5, -2
AB85 // 16 ST   r5, r6, 5
A586 // 17 ST   r2, r6, 6     SLBI result
7A20 // 18 LBI  r5, 0x20      RAM base
A740 // 19 ST   r3, r5, 0
A341 // 20 ST   r1, r5, 1
6941 // 21 ADDI r4, r5, 1     computed load address
9540 // 22 LD   r2, r5, 0
9700 // 23 LD   r3, r4, 0
A587 // 24 ST   r2, r6, 7
A788 // 25 ST   r3, r6, 8
7200 // 26 LBI  r1, 0
B201 // 27 BEQZ r1, +1        taken
A39F // 28 ST   r1, r6, 31    skipped
74A1 // 29 LBI  r2, 0xa1
A589 // 30 ST   r2, r6, 9
C201 // 31 BNEZ r1, +1        not taken
74A2 // 32 LBI  r2, 0xa2
A58A // 33 ST   r2, r6, 10
C401 // 34 BNEZ r2, +1        taken
A59E // 35 ST   r2, r6, 30    skipped
B401 // 36 BEQZ r2, +1        not taken
74A3 // 37 LBI  r2, 0xa3
A58B // 38 ST   r2, r6, 11
D001 // 39 J    +1
A39D // 40 ST   r1, r6, 29    skipped
E004 // 41 JAL  +4            r7 = 42
74B0 // 42 LBI  r2, 0xb0      return lands here
A58D // 43 ST   r2, r6, 13
9380 // 44 LD   r1, r6, 0     load from output region, err trap
0000 // 45 HALT
AF8C // 46 ST   r7, r6, 12    subroutine
F1C0 // 47 JR   r7, 0

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module procTb -o procSim

output=$(./obj_dir/procSim 2>&1) || true
echo "$output"

if grep -qxF "Test OK" <<< "$output"; then
   exit 0
else
   exit 1
fi
